//--- front_end_pkg.sv
package front_end_pkg;

    // Widths that follow directly from the RV32I instruction set
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] imm_t;
    typedef logic [6:0]  opcode_t;

    // Address the program counter takes when reset is released
    localparam addr_t RESET_PC = 32'h0000_0000;

    // Every supported instruction is one full word
    localparam logic [31:0] INSTR_BYTES = 32'd4;

    // ADDI x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // Major opcodes of the base integer set
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_FENCE  = 7'b0001111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // States of the instruction cache request machine in the fetch stage
    typedef enum logic [1:0] {
        IDLE,
        CACHE_OUTCOME,
        WAIT_MEMORY,
        WAIT_DISCARD
    } fetch_state_t;

endpackage : front_end_pkg

//--- fetch_decode_if.sv
interface fetch_decode_if;
    import front_end_pkg::*;

    // Fetch register contents offered to decode
    logic   valid;
    addr_t  pc;
    instr_t instr;

    // High when the decode register can take a new item this cycle
    logic   ready;

    modport fetch (
        output valid,
        output pc,
        output instr,
        input  ready
    );

    modport decode (
        input  valid,
        input  pc,
        input  instr,
        output ready
    );

endinterface : fetch_decode_if

//--- pc_gen.sv
module pc_gen (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Exception unit
    input  logic                 exception_i,
    input  logic                 interrupt_i,
    input  front_end_pkg::addr_t handler_pc_i,

    // Branch resolution from execute
    input  logic                 executed_i,
    input  logic                 taken_i,
    input  front_end_pkg::addr_t branch_target_addr_i,

    // One pulse per instruction accepted by fetch
    input  logic                 advance_i,

    output front_end_pkg::addr_t pc_o,
    output logic                 redirect_o
);
    import front_end_pkg::*;

    addr_t program_counter;
    logic  handler_redirect;
    logic  branch_redirect;

    assign handler_redirect = exception_i || interrupt_i;

    // Prediction is always not-taken, so every taken resolution is a recovery
    assign branch_redirect = executed_i && taken_i;

    assign redirect_o = handler_redirect || branch_redirect;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            program_counter <= RESET_PC;
        end else if (handler_redirect) begin
            // The handler always wins over a branch resolved in the same cycle
            program_counter <= handler_pc_i;
        end else if (branch_redirect) begin
            program_counter <= branch_target_addr_i;
        end else if (advance_i) begin
            program_counter <= program_counter + INSTR_BYTES;
        end
    end

    assign pc_o = program_counter;

endmodule : pc_gen

//--- fetch_stage.sv
module fetch_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // From PC generation
    input  front_end_pkg::addr_t  pc_i,
    input  logic                  redirect_i,
    output logic                  advance_o,

    // Instruction cache strobes
    output logic                  icache_request_o,
    output front_end_pkg::addr_t  icache_address_o,
    input  logic                  icache_hit_i,
    output logic                  icache_access_o,
    input  logic                  icache_fill_i,
    input  front_end_pkg::instr_t icache_instr_i,

    // Fetch register towards decode
    fetch_decode_if.fetch         fd
);
    import front_end_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;

    logic slot_free;
    logic capture;

    // The slot can accept a word if it is empty or hands its item over this cycle
    assign slot_free = !fd.valid || fd.ready;

    // The PC only moves on a capture or a redirect, so it stays the address
    // of the outstanding request for the whole cache transaction
    assign icache_address_o = pc_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next       = state;
        icache_request_o = 1'b0;
        icache_access_o  = 1'b0;
        capture          = 1'b0;

        case (state)
            IDLE: begin
                // A redirecting PC is stale, wait for the new one next cycle
                if (slot_free && !redirect_i) begin
                    icache_request_o = 1'b1;
                    state_next       = CACHE_OUTCOME;
                end
            end

            CACHE_OUTCOME: begin
                if (redirect_i) begin
                    // The outcome belongs to the old path, drop it and skip any refill
                    state_next = IDLE;
                end else if (icache_hit_i) begin
                    capture    = 1'b1;
                    state_next = IDLE;
                end else begin
                    icache_access_o = 1'b1;
                    state_next      = WAIT_MEMORY;
                end
            end

            WAIT_MEMORY: begin
                if (redirect_i) begin
                    // The refill cannot be cancelled, so it has to be absorbed
                    state_next = icache_fill_i ? IDLE : WAIT_DISCARD;
                end else if (icache_fill_i) begin
                    capture    = 1'b1;
                    state_next = IDLE;
                end
            end

            WAIT_DISCARD: begin
                if (icache_fill_i) begin
                    state_next = IDLE;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // The PC steps to the next word exactly when this one is taken in
    assign advance_o = capture;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || redirect_i) begin
            fd.valid <= 1'b0;
        end else if (capture) begin
            fd.valid <= 1'b1;
        end else if (fd.ready) begin
            fd.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            fd.pc    <= pc_i;
            fd.instr <= icache_instr_i;
        end
    end

endmodule : fetch_stage

//--- decode_stage.sv
module decode_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    stall_i,
    input  logic                    redirect_i,

    // Fetch register
    fetch_decode_if.decode          fd,

    // Decoded instruction towards the backend
    output logic                    valid_o,
    output front_end_pkg::addr_t    pc_o,
    output logic                    branch_o,
    output logic                    jump_o,
    output logic                    memory_o,
    output logic                    fence_o,
    output logic                    illegal_o,
    output front_end_pkg::reg_idx_t rs1_o,
    output front_end_pkg::reg_idx_t rs2_o,
    output front_end_pkg::reg_idx_t rd_o,
    output front_end_pkg::imm_t     immediate_o
);
    import front_end_pkg::*;

    instr_t  instr;
    opcode_t opcode;

    logic dec_branch;
    logic dec_jump;
    logic dec_memory;
    logic dec_fence;
    logic dec_illegal;
    imm_t dec_immediate;

    logic handoff;

    assign instr  = fd.instr;
    assign opcode = instr[6:0];

    always_comb begin
        dec_branch    = 1'b0;
        dec_jump      = 1'b0;
        dec_memory    = 1'b0;
        dec_fence     = 1'b0;
        dec_illegal   = 1'b0;
        dec_immediate = '0;

        if (instr[1:0] != 2'b11) begin
            // Compressed encodings are not supported by this front end
            dec_illegal = 1'b1;
        end else begin
            case (opcode)
                OPC_LUI, OPC_AUIPC: begin
                    dec_immediate = {instr[31:12], 12'b0};
                end

                OPC_JAL: begin
                    dec_jump      = 1'b1;
                    dec_immediate = {{11{instr[31]}}, instr[31], instr[19:12],
                                     instr[20], instr[30:21], 1'b0};
                end

                OPC_JALR: begin
                    dec_jump      = 1'b1;
                    dec_immediate = {{20{instr[31]}}, instr[31:20]};
                end

                OPC_BRANCH: begin
                    dec_branch    = 1'b1;
                    dec_immediate = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
                end

                OPC_LOAD: begin
                    dec_memory    = 1'b1;
                    dec_immediate = {{20{instr[31]}}, instr[31:20]};
                end

                OPC_STORE: begin
                    dec_memory    = 1'b1;
                    dec_immediate = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end

                OPC_OP_IMM, OPC_SYSTEM: begin
                    dec_immediate = {{20{instr[31]}}, instr[31:20]};
                end

                OPC_FENCE: begin
                    dec_fence     = 1'b1;
                    dec_immediate = {{20{instr[31]}}, instr[31:20]};
                end

                // Register to register operations carry no immediate
                OPC_OP: begin
                    dec_immediate = '0;
                end

                default: begin
                    dec_illegal = 1'b1;
                end
            endcase
        end
    end

    // Empty, or about to be consumed by a backend that is not stalled
    assign fd.ready = !valid_o || !stall_i;
    assign handoff  = fd.valid && fd.ready;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || redirect_i) begin
            valid_o <= 1'b0;
        end else if (fd.ready) begin
            valid_o <= fd.valid;
        end
    end

    // Payload only moves on a handoff, so it holds under stall
    always_ff @(posedge clk_i) begin
        if (handoff) begin
            pc_o        <= fd.pc;
            branch_o    <= dec_branch;
            jump_o      <= dec_jump;
            memory_o    <= dec_memory;
            fence_o     <= dec_fence;
            illegal_o   <= dec_illegal;
            rs1_o       <= instr[19:15];
            rs2_o       <= instr[24:20];
            rd_o        <= instr[11:7];
            immediate_o <= dec_immediate;
        end
    end

endmodule : decode_stage

//--- front_end.sv
module front_end (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    stall_i,

    // Handler redirect from the exception unit
    input  logic                    exception_i,
    input  logic                    interrupt_i,
    input  front_end_pkg::addr_t    handler_pc_i,

    // Branch resolution from execute
    input  logic                    executed_i,
    input  logic                    taken_i,
    input  front_end_pkg::addr_t    branch_target_addr_i,

    // Instruction cache
    output logic                    icache_request_o,
    output front_end_pkg::addr_t    icache_address_o,
    output logic                    icache_access_o,
    input  logic                    icache_hit_i,
    input  logic                    icache_fill_i,
    input  front_end_pkg::instr_t   icache_instr_i,

    // Decoded instruction
    output logic                    valid_o,
    output front_end_pkg::addr_t    pc_o,
    output logic                    branch_o,
    output logic                    jump_o,
    output logic                    memory_o,
    output logic                    fence_o,
    output logic                    illegal_o,
    output front_end_pkg::reg_idx_t rs1_o,
    output front_end_pkg::reg_idx_t rs2_o,
    output front_end_pkg::reg_idx_t rd_o,
    output front_end_pkg::imm_t     immediate_o
);
    import front_end_pkg::*;

    addr_t fetch_pc;
    logic  redirect;
    logic  advance;

    fetch_decode_if fd_if ();

    pc_gen pc_gen0 (
        .clk_i                ( clk_i                ),
        .rst_n_i              ( rst_n_i              ),
        .exception_i          ( exception_i          ),
        .interrupt_i          ( interrupt_i          ),
        .handler_pc_i         ( handler_pc_i         ),
        .executed_i           ( executed_i           ),
        .taken_i              ( taken_i              ),
        .branch_target_addr_i ( branch_target_addr_i ),
        .advance_i            ( advance              ),
        .pc_o                 ( fetch_pc             ),
        .redirect_o           ( redirect             )
    );

    fetch_stage fetch0 (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .pc_i             ( fetch_pc         ),
        .redirect_i       ( redirect         ),
        .advance_o        ( advance          ),
        .icache_request_o ( icache_request_o ),
        .icache_address_o ( icache_address_o ),
        .icache_hit_i     ( icache_hit_i     ),
        .icache_access_o  ( icache_access_o  ),
        .icache_fill_i    ( icache_fill_i    ),
        .icache_instr_i   ( icache_instr_i   ),
        .fd               ( fd_if.fetch      )
    );

    decode_stage decode0 (
        .clk_i       ( clk_i        ),
        .rst_n_i     ( rst_n_i      ),
        .stall_i     ( stall_i      ),
        .redirect_i  ( redirect     ),
        .fd          ( fd_if.decode ),
        .valid_o     ( valid_o      ),
        .pc_o        ( pc_o         ),
        .branch_o    ( branch_o     ),
        .jump_o      ( jump_o       ),
        .memory_o    ( memory_o     ),
        .fence_o     ( fence_o      ),
        .illegal_o   ( illegal_o    ),
        .rs1_o       ( rs1_o        ),
        .rs2_o       ( rs2_o        ),
        .rd_o        ( rd_o         ),
        .immediate_o ( immediate_o  )
    );

endmodule : front_end

//--- tb_icache_model.sv
module tb_icache_model (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  request_i,
    input  front_end_pkg::addr_t  address_i,
    input  logic                  access_i,
    output logic                  hit_o,
    output logic                  fill_o,
    output front_end_pkg::instr_t instr_o
);
    import front_end_pkg::*;

    // Program image and the lines that have been refilled so far
    instr_t image [64];
    logic   filled [64];

    logic       rst_q;
    logic       req_q;
    logic       acc_q;
    addr_t      addr_q;
    logic [5:0] miss_index;
    logic [2:0] fill_delay;

    // Every fifth word misses until its first refill
    function automatic logic is_miss(logic [5:0] idx);
        return (int'(idx) % 5 == 0) && !filled[idx];
    endfunction

    // All legal opcodes appear at least once, then a random mix follows
    task automatic build_image();
        opcode_t legal_ops [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                    OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_FENCE,
                                    OPC_SYSTEM};
        instr_t word;
        int     pick;
        for (int i = 0; i < 64; i++) begin
            word = $urandom;
            pick = int'($urandom % 11);
            if (i < 11) begin
                word[6:0] = legal_ops[i];
            end else if (i == 11 || $urandom % 8 == 0) begin
                // Custom opcode space, not part of the base set
                word[6:0] = 7'b0001011;
            end else if (i == 12 || $urandom % 8 == 0) begin
                word[1:0] = 2'($urandom % 3);
            end else begin
                word[6:0] = legal_ops[pick];
            end
            image[i]  = word;
            filled[i] = 1'b0;
        end
    endtask

    task automatic invalidate();
        for (int i = 0; i < 64; i++) begin
            filled[i] = 1'b0;
        end
    endtask

    always @(posedge clk_i) begin
        rst_q  <= rst_n_i;
        req_q  <= request_i;
        acc_q  <= access_i;
        addr_q <= address_i;
    end

    // Responses change on the falling edge, one cycle after the strobe
    initial begin
        hit_o      = 1'b0;
        fill_o     = 1'b0;
        instr_o    = NOP_INSTR;
        fill_delay = '0;
        miss_index = '0;
        forever begin
            @(negedge clk_i);
            hit_o  = 1'b0;
            fill_o = 1'b0;
            if (!rst_q) begin
                fill_delay = '0;
            end else begin
                if (req_q) begin
                    hit_o = !is_miss(addr_q[7:2]);
                    if (hit_o) begin
                        instr_o = image[addr_q[7:2]];
                    end else begin
                        miss_index = addr_q[7:2];
                    end
                end
                if (acc_q) begin
                    fill_delay = 3'(($urandom % 4) + 1);
                end else if (fill_delay != 0) begin
                    fill_delay = fill_delay - 3'd1;
                    if (fill_delay == 0) begin
                        fill_o             = 1'b1;
                        instr_o            = image[miss_index];
                        filled[miss_index] = 1'b1;
                    end
                end
            end
        end
    end

endmodule : tb_icache_model

//--- front_end_tb.sv
module front_end_tb;
    import front_end_pkg::*;

    localparam int unsigned TIMEOUT_CYCLES = 3000;
    localparam logic [31:0] SEED = 32'hde7c_6c1a;

    logic     clk_i;
    logic     rst_n_i;
    logic     stall_i;
    logic     exception_i;
    logic     interrupt_i;
    addr_t    handler_pc_i;
    logic     executed_i;
    logic     taken_i;
    addr_t    branch_target_addr_i;
    logic     icache_request_o;
    addr_t    icache_address_o;
    logic     icache_access_o;
    logic     icache_hit_i;
    logic     icache_fill_i;
    instr_t   icache_instr_i;
    logic     valid_o;
    addr_t    pc_o;
    logic     branch_o;
    logic     jump_o;
    logic     memory_o;
    logic     fence_o;
    logic     illegal_o;
    reg_idx_t rs1_o;
    reg_idx_t rs2_o;
    reg_idx_t rd_o;
    imm_t     immediate_o;

    addr_t       expected_pc;
    instr_t      expected_word;
    logic [4:0]  exp_class;
    imm_t        exp_imm;
    logic        redirect_in;
    logic        fill_outstanding;
    int unsigned accepted;
    int unsigned cycle_count;

    front_end dut0 (.*);

    tb_icache_model cache0 (
        .clk_i     ( clk_i            ),
        .rst_n_i   ( rst_n_i          ),
        .request_i ( icache_request_o ),
        .address_i ( icache_address_o ),
        .access_i  ( icache_access_o  ),
        .hit_o     ( icache_hit_i     ),
        .fill_o    ( icache_fill_i    ),
        .instr_o   ( icache_instr_i   )
    );

    // Class flags packed as {branch, jump, memory, fence, illegal}
    function automatic logic [4:0] ref_class(instr_t w);
        if (w[1:0] != 2'b11) begin
            return 5'b00001;
        end
        case (w[6:0])
            OPC_BRANCH:                                        return 5'b10000;
            OPC_JAL, OPC_JALR:                                 return 5'b01000;
            OPC_LOAD, OPC_STORE:                               return 5'b00100;
            OPC_FENCE:                                         return 5'b00010;
            OPC_LUI, OPC_AUIPC, OPC_OP_IMM, OPC_OP, OPC_SYSTEM: return 5'b00000;
            default:                                           return 5'b00001;
        endcase
    endfunction

    function automatic imm_t ref_imm(instr_t w);
        logic [4:0] cls;
        imm_t i_imm;
        imm_t s_imm;
        imm_t b_imm;
        imm_t u_imm;
        imm_t j_imm;
        cls   = ref_class(w);
        i_imm = imm_t'($signed(w[31:20]));
        s_imm = imm_t'($signed({w[31:25], w[11:7]}));
        b_imm = imm_t'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        u_imm = {w[31:12], 12'h000};
        j_imm = imm_t'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        if (cls[0] == 1'b1) begin
            return '0;
        end
        case (w[6:0])
            OPC_LUI, OPC_AUIPC:                         return u_imm;
            OPC_JAL:                                    return j_imm;
            OPC_BRANCH:                                 return b_imm;
            OPC_STORE:                                  return s_imm;
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_FENCE,
            OPC_SYSTEM:                                 return i_imm;
            default:                                    return '0;
        endcase
    endfunction

    task automatic value_error(string name, logic [31:0] expected, logic [31:0] actual);
        $display("[FAIL] %s expected %h got %h", name, expected, actual);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic run_error(string what);
        $display("[FAIL] %s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // Holds the resolution inputs for one cycle from the falling edge it starts on
    task automatic drive_resolution(logic exc, logic irq, logic taken, addr_t handler,
                                    addr_t target);
        exception_i          = exc;
        interrupt_i          = irq;
        executed_i           = 1'b1;
        taken_i              = taken;
        handler_pc_i         = handler;
        branch_target_addr_i = target;
        @(negedge clk_i);
        exception_i = 1'b0;
        interrupt_i = 1'b0;
        executed_i  = 1'b0;
        taken_i     = 1'b0;
    endtask

    // Lets the given number of items leave decode under random stalls
    task automatic run_items(int unsigned count);
        int unsigned target;
        target = accepted + count;
        while (accepted < target) begin
            @(negedge clk_i);
            stall_i = ($urandom % 4 == 0);
        end
        stall_i = 1'b0;
    endtask

    assign redirect_in   = exception_i || interrupt_i || (executed_i && taken_i);
    assign expected_word = cache0.image[expected_pc[7:2]];
    assign exp_class     = ref_class(expected_word);
    assign exp_imm       = ref_imm(expected_word);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Reference model of the program order seen at the decode outputs
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            expected_pc      <= RESET_PC;
            accepted         <= 0;
            fill_outstanding <= 1'b0;
        end else begin
            if (exception_i || interrupt_i) begin
                expected_pc <= handler_pc_i;
            end else if (executed_i && taken_i) begin
                expected_pc <= branch_target_addr_i;
            end else if (valid_o && !stall_i) begin
                expected_pc <= expected_pc + INSTR_BYTES;
            end
            if (valid_o && !stall_i) begin
                accepted <= accepted + 1;
            end
            if (icache_access_o) begin
                fill_outstanding <= 1'b1;
            end else if (icache_fill_i) begin
                fill_outstanding <= 1'b0;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            run_error("run did not finish within the cycle limit");
        end
    end

    assert property (@(posedge clk_i) $rose(rst_n_i) |-> !valid_o && !icache_access_o)
        else run_error("front end was not idle when reset was released");

    assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_o |-> pc_o == expected_pc)
        else value_error("pc_o", $sampled(expected_pc), $sampled(pc_o));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> {branch_o, jump_o, memory_o, fence_o, illegal_o} == exp_class)
        else value_error("{branch_o,jump_o,memory_o,fence_o,illegal_o}",
                         32'($sampled(exp_class)),
                         32'($sampled({branch_o, jump_o, memory_o, fence_o, illegal_o})));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> immediate_o == exp_imm)
        else value_error("immediate_o", $sampled(exp_imm), $sampled(immediate_o));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> rs1_o == expected_word[19:15])
        else value_error("rs1_o", 32'($sampled(expected_word[19:15])), 32'($sampled(rs1_o)));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> rs2_o == expected_word[24:20])
        else value_error("rs2_o", 32'($sampled(expected_word[24:20])), 32'($sampled(rs2_o)));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> rd_o == expected_word[11:7])
        else value_error("rd_o", 32'($sampled(expected_word[11:7])), 32'($sampled(rd_o)));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && illegal_o |-> !(branch_o || jump_o || memory_o || fence_o))
        else run_error("an illegal word also carried a class flag");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        icache_access_o |-> $past(icache_request_o) && !icache_hit_i)
        else run_error("memory access started without a missed request");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_outstanding |-> !icache_request_o)
        else run_error("cache request issued while a refill was outstanding");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && stall_i && !redirect_in |=> valid_o && $stable(pc_o)
            && $stable({branch_o, jump_o, memory_o, fence_o, illegal_o})
            && $stable({rs1_o, rs2_o, rd_o}) && $stable(immediate_o))
        else run_error("decoded outputs changed while the backend was stalled");

    initial begin
        rst_n_i              = 1'b0;
        stall_i              = 1'b0;
        exception_i          = 1'b0;
        interrupt_i          = 1'b0;
        handler_pc_i         = '0;
        executed_i           = 1'b0;
        taken_i              = 1'b0;
        branch_target_addr_i = '0;
        cycle_count          = 0;
        void'($urandom(SEED));
        cache0.build_image();

        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;

        run_items(40);
        drive_resolution(1'b0, 1'b0, 1'b1, '0, 32'h0000_0040);
        run_items(6);
        drive_resolution(1'b0, 1'b0, 1'b0, '0, 32'h0000_0010);
        run_items(4);
        // An exception and a taken branch arrive together and the handler wins
        drive_resolution(1'b1, 1'b0, 1'b1, 32'h0000_00c0, 32'h0000_0010);
        run_items(6);
        drive_resolution(1'b0, 1'b1, 1'b0, 32'h0000_0064, '0);
        run_items(5);

        // Second redirect lands while the first target is still refilling
        @(posedge clk_i);
        cache0.invalidate();
        @(negedge clk_i);
        drive_resolution(1'b0, 1'b0, 1'b1, '0, 32'h0000_00a0);
        while (!fill_outstanding) begin
            @(negedge clk_i);
        end
        drive_resolution(1'b0, 1'b0, 1'b1, '0, 32'h0000_0028);
        run_items(8);

        repeat (6) begin
            run_items(($urandom % 5) + 1);
            case ($urandom % 3)
                0: drive_resolution(1'b0, 1'b0, 1'b1, '0, addr_t'(($urandom % 64) * 4));
                1: drive_resolution(1'b1, 1'b0, 1'b0, addr_t'(($urandom % 64) * 4), '0);
                default: drive_resolution(1'b0, 1'b1, 1'b1, addr_t'(($urandom % 64) * 4),
                                          addr_t'(($urandom % 64) * 4));
            endcase
        end
        run_items(10);

        $display(">>> PASS");
        $finish;
    end

endmodule : front_end_tb

//--- vlog.f
front_end_pkg.sv
fetch_decode_if.sv
pc_gen.sv
fetch_stage.sv
decode_stage.sv
front_end.sv
tb_icache_model.sv
front_end_tb.sv

//--- Makefile
VERILATOR    ?= verilator
TOP          := front_end_tb
RTL_TOP      := front_end
FILELIST     := vlog.f
BUILD_DIR    := obj_dir
LOG          := sim.log
COMMON_FLAGS := --timing --assert
LINT_FLAGS   := --lint-only -Wall
SIM_FLAGS    := --binary -j 0 --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) -f $(FILELIST) --top-module $(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
